// ==== verilog/rv_cfg.svh ====
// execute core configuration: word widths, major opcodes and ALU operation codes
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

`define RV_XLEN        32
`define RV_REG_ADDR_W  5
`define RV_NUM_REGS    32
`define RV_HALF        16   // split point for shifts and compares
`define RV_ALUOP_W     4

// major opcodes
`define RV_OPC_OP      7'b0110011
`define RV_OPC_OPIMM   7'b0010011
`define RV_OPC_LUI     7'b0110111

// alu codes are {funct7[5], funct3}
`define RV_ALUOP_ADD   4'b0000
`define RV_ALUOP_SUB   4'b1000
`define RV_ALUOP_SLL   4'b0001
`define RV_ALUOP_SLT   4'b0010
`define RV_ALUOP_SLTU  4'b0011
`define RV_ALUOP_XOR   4'b0100
`define RV_ALUOP_SRL   4'b0101
`define RV_ALUOP_SRA   4'b1101
`define RV_ALUOP_OR    4'b0110
`define RV_ALUOP_AND   4'b0111

`endif

// ==== verilog/rv_pkg.sv ====
// rv_pkg: instruction word formats of the RV32I execute core
`include "rv_cfg.svh"

package rv_pkg;

   typedef struct packed {
      logic [6:0]                funct7;
      logic [`RV_REG_ADDR_W-1:0] rs2;
      logic [`RV_REG_ADDR_W-1:0] rs1;
      logic [2:0]                funct3;
      logic [`RV_REG_ADDR_W-1:0] rd;
      logic [6:0]                opcode;
   } r_fmt;

   typedef struct packed {
      logic [11:0]               imm;   // sign extended by the decoder
      logic [`RV_REG_ADDR_W-1:0] rs1;
      logic [2:0]                funct3;
      logic [`RV_REG_ADDR_W-1:0] rd;
      logic [6:0]                opcode;
   } i_fmt;

   typedef struct packed {
      logic [19:0]               imm;   // lands in bits 31:12
      logic [`RV_REG_ADDR_W-1:0] rd;
      logic [6:0]                opcode;
   } u_fmt;

   // one 32-bit word, viewed by format
   typedef union packed {
      r_fmt r;
      i_fmt i;
      u_fmt u;
   } inst_u;

endpackage

// ==== verilog/issue_if.sv ====
// issue_if: one issued operation, from issue control to the ALU
`include "rv_cfg.svh"

interface issue_if;

   logic                      valid;    // one cycle per issued instruction
   logic [`RV_REG_ADDR_W-1:0] rd;
   logic [`RV_ALUOP_W-1:0]    alu_op;
   logic [`RV_XLEN-1:0]       imm;
   logic                      use_imm;

   modport master (output valid, output rd, output alu_op, output imm, output use_imm);
   modport slave (input valid, input rd, input alu_op, input imm, input use_imm);

endinterface

// ==== verilog/inst_decoder.sv ====
// inst_decoder: splits an RV32I word into operands, immediate, ALU operation and legality
`include "rv_cfg.svh"

module inst_decoder (
   input  rv_pkg::inst_u             i_inst,
   output logic [`RV_REG_ADDR_W-1:0] o_rs1,
   output logic [`RV_REG_ADDR_W-1:0] o_rs2,
   output logic [`RV_REG_ADDR_W-1:0] o_rd,
   output logic [`RV_XLEN-1:0]       o_imm,
   output logic [`RV_ALUOP_W-1:0]    o_alu_op,
   output logic                      o_use_imm,
   output logic                      o_uses_rs2,
   output logic                      o_illegal
);

   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       is_shift;

   assign funct3   = i_inst.r.funct3;
   assign funct7   = i_inst.r.funct7;
   assign is_shift = funct3[1:0] == 2'b01;   // sll / srl / sra
   assign o_rs2    = i_inst.r.rs2;
   assign o_rd     = i_inst.r.rd;

   always_comb begin
      o_illegal  = 1'b0;
      o_alu_op   = `RV_ALUOP_ADD;
      o_use_imm  = 1'b1;
      o_uses_rs2 = 1'b0;
      o_rs1      = i_inst.i.rs1;
      o_imm      = {{(`RV_XLEN-12){i_inst.i.imm[11]}}, i_inst.i.imm};
      case (i_inst.r.opcode)
         `RV_OPC_OP: begin
            o_use_imm  = 1'b0;
            o_uses_rs2 = 1'b1;
            o_alu_op   = {funct7[5], funct3};
            if (funct7 != 7'h00 && funct7 != 7'h20)
               o_illegal = 1'b1;
            if (funct7 == 7'h20 && funct3 != 3'b000 && funct3 != 3'b101)
               o_illegal = 1'b1;   // only sub and sra take funct7 bit 5
         end
         `RV_OPC_OPIMM: begin
            // funct7 is part of the immediate except on shifts
            o_alu_op = {is_shift & funct7[5], funct3};
            if (funct3 == 3'b001 && funct7 != 7'h00)
               o_illegal = 1'b1;
            if (funct3 == 3'b101 && funct7 != 7'h00 && funct7 != 7'h20)
               o_illegal = 1'b1;
         end
         `RV_OPC_LUI: begin
            o_rs1 = '0;   // x0 + imm
            o_imm = {i_inst.u.imm, 12'b0};
         end
         default: o_illegal = 1'b1;
      endcase
   end

endmodule

// ==== verilog/issue_ctrl.sv ====
// issue_ctrl: input handshake, register busy scoreboard and issue stage registers
`include "rv_cfg.svh"

module issue_ctrl (
   input  logic                      i_clk,
   input  logic                      i_rst,
   input  logic                      i_inst_valid,
   output logic                      o_inst_ready,
   input  logic [`RV_REG_ADDR_W-1:0] i_rs1,
   input  logic [`RV_REG_ADDR_W-1:0] i_rs2,
   input  logic                      i_uses_rs2,
   input  logic [`RV_REG_ADDR_W-1:0] i_rd,
   input  logic [`RV_XLEN-1:0]       i_imm,
   input  logic [`RV_ALUOP_W-1:0]    i_alu_op,
   input  logic                      i_use_imm,
   input  logic                      i_dec_illegal,
   output logic [`RV_REG_ADDR_W-1:0] o_rd_addr1,
   output logic [`RV_REG_ADDR_W-1:0] o_rd_addr2,
   input  logic                      i_wb_valid,
   input  logic [`RV_REG_ADDR_W-1:0] i_wb_rd,
   output logic                      o_illegal,
   issue_if.master                   iss
);

   logic [`RV_NUM_REGS-1:0] busy;
   logic                    accept;
   logic                    issue_go;
   logic                    wr_go;

   assign o_inst_ready = !(busy[i_rs1] || (i_uses_rs2 && busy[i_rs2]));
   assign accept       = i_inst_valid && o_inst_ready;
   assign issue_go     = accept && !i_dec_illegal;
   assign wr_go        = issue_go && !i_rst && (i_rd != '0);

   // regfile samples these on the acceptance edge
   assign o_rd_addr1 = i_rs1;
   assign o_rd_addr2 = i_rs2;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         busy <= '0;
      end else begin
         if (i_wb_valid)
            busy[i_wb_rd] <= 1'b0;
         if (wr_go)
            busy[i_rd] <= 1'b1;   // new writer wins over a retiring one
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         iss.valid <= 1'b0;
         o_illegal <= 1'b0;
      end else begin
         iss.valid <= issue_go;
         o_illegal <= accept && i_dec_illegal;
      end
   end

   always_ff @(posedge i_clk) begin
      if (issue_go) begin
         iss.rd      <= i_rd;
         iss.alu_op  <= i_alu_op;
         iss.imm     <= i_imm;
         iss.use_imm <= i_use_imm;
      end
   end

   function automatic logic src_hit(input logic [`RV_REG_ADDR_W-1:0] rs1,
                                    input logic [`RV_REG_ADDR_W-1:0] rs2,
                                    input logic                      uses2,
                                    input logic [`RV_REG_ADDR_W-1:0] r);
      src_hit = (rs1 == r) || (uses2 && rs2 == r);
   endfunction

   // a result is not readable until its writeback has retired, three edges on
   a_no_early_read: assert property (@(posedge i_clk) disable iff (i_rst)
      accept |->
         !($past(wr_go, 1) && src_hit(i_rs1, i_rs2, i_uses_rs2, $past(i_rd, 1))) &&
         !($past(wr_go, 2) && src_hit(i_rs1, i_rs2, i_uses_rs2, $past(i_rd, 2))) &&
         !($past(wr_go, 3) && src_hit(i_rs1, i_rs2, i_uses_rs2, $past(i_rd, 3))));

endmodule

// ==== verilog/regfile.sv ====
// regfile: 32 x 32-bit registers, two synchronous read ports with write forwarding
`include "rv_cfg.svh"

module regfile (
   input  logic                      i_clk,
   input  logic                      i_we,
   input  logic [`RV_REG_ADDR_W-1:0] i_wa,
   input  logic [`RV_XLEN-1:0]       i_wd,
   input  logic [`RV_REG_ADDR_W-1:0] i_ra1,
   input  logic [`RV_REG_ADDR_W-1:0] i_ra2,
   output logic [`RV_XLEN-1:0]       o_rd1,
   output logic [`RV_XLEN-1:0]       o_rd2
);

   logic [`RV_XLEN-1:0]        mem [`RV_NUM_REGS];
   logic [`RV_XLEN-1:0]        rdata1_q, rdata2_q;
   logic [`RV_REG_ADDR_W-1:0]  ra1_q, ra2_q;
   logic                       fwd1_q, fwd2_q;
   logic [`RV_XLEN-1:0]        wd_q;
   logic                       we_nz;

   assign we_nz = i_we && (i_wa != '0);   // x0 writes dropped

   always_ff @(posedge i_clk) begin
      if (we_nz)
         mem[i_wa] <= i_wd;
      rdata1_q <= (i_ra1 == '0) ? '0 : mem[i_ra1];
      rdata2_q <= (i_ra2 == '0) ? '0 : mem[i_ra2];
      ra1_q    <= i_ra1;
      ra2_q    <= i_ra2;
      fwd1_q   <= we_nz && (i_wa == i_ra1);   // write on the sampling edge
      fwd2_q   <= we_nz && (i_wa == i_ra2);
      wd_q     <= i_wd;
   end

   // write pending now, then write from the sampling edge, then the array
   assign o_rd1 = (we_nz && i_wa == ra1_q) ? i_wd : fwd1_q ? wd_q : rdata1_q;
   assign o_rd2 = (we_nz && i_wa == ra2_q) ? i_wd : fwd2_q ? wd_q : rdata2_q;

   a_x0_rd1: assert property (@(posedge i_clk) (i_ra1 == '0) |=> (o_rd1 == '0));
   a_x0_rd2: assert property (@(posedge i_clk) (i_ra2 == '0) |=> (o_rd2 == '0));

endmodule

// ==== verilog/exec_alu.sv ====
// exec_alu: two-stage ALU with 16-bit split shifts and compares, drives writeback
`include "rv_cfg.svh"

module exec_alu (
   input  logic                      i_clk,
   input  logic                      i_rst,
   issue_if.slave                    iss,
   input  logic [`RV_XLEN-1:0]       i_rs1_data,
   input  logic [`RV_XLEN-1:0]       i_rs2_data,
   output logic                      o_wb_valid,
   output logic [`RV_REG_ADDR_W-1:0] o_wb_rd,
   output logic [`RV_XLEN-1:0]       o_wb_data
);

   localparam int XW   = `RV_XLEN;
   localparam int H    = `RV_HALF;
   localparam int SH_W = $clog2(`RV_HALF);

   // stage one
   logic                      valid_p;
   logic [`RV_ALUOP_W-1:0]    op_p;
   logic [`RV_REG_ADDR_W-1:0] rd_p;
   logic [XW-1:0]             op1_p, op2_p;

   // stage two
   logic                      valid_pp;
   logic [`RV_ALUOP_W-1:0]    op_pp;
   logic [`RV_REG_ADDR_W-1:0] rd_pp;
   logic [XW-1:0]             add_pp, sub_pp, sll_pp, srl_pp, sra_pp;
   logic [XW-1:0]             xor_pp, or_pp, and_pp;
   logic                      slt_pp, sh16_pp;
   logic                      ltu_hi_pp, eq_hi_pp, ltu_lo_pp;

   logic [XW-1:0]             sub_w;
   logic                      ovf;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         valid_p  <= 1'b0;
         valid_pp <= 1'b0;
      end else begin
         valid_p  <= iss.valid;
         valid_pp <= valid_p;
      end
   end

   always_ff @(posedge i_clk) begin
      op_p  <= iss.alu_op;
      rd_p  <= iss.rd;
      op1_p <= i_rs1_data;
      op2_p <= iss.use_imm ? iss.imm : i_rs2_data;
   end

   assign sub_w = op1_p - op2_p;
   assign ovf   = (op1_p[XW-1] ^ op2_p[XW-1]) & (sub_w[XW-1] ^ op1_p[XW-1]);

   always_ff @(posedge i_clk) begin
      op_pp     <= op_p;
      rd_pp     <= rd_p;
      add_pp    <= op1_p + op2_p;
      sub_pp    <= sub_w;
      slt_pp    <= sub_w[XW-1] ^ ovf;
      sll_pp    <= op1_p << op2_p[SH_W-1:0];   // low 4 bits only
      srl_pp    <= op1_p >> op2_p[SH_W-1:0];
      sra_pp    <= $signed(op1_p) >>> op2_p[SH_W-1:0];
      sh16_pp   <= op2_p[SH_W];                // extra 16 applied after
      ltu_hi_pp <= op1_p[H+:H] < op2_p[H+:H];
      eq_hi_pp  <= op1_p[H+:H] == op2_p[H+:H];
      ltu_lo_pp <= op1_p[0+:H] < op2_p[0+:H];
      xor_pp    <= op1_p ^ op2_p;
      or_pp     <= op1_p | op2_p;
      and_pp    <= op1_p & op2_p;
   end

   always_comb begin
      case (op_pp)
         `RV_ALUOP_ADD:  o_wb_data = add_pp;
         `RV_ALUOP_SUB:  o_wb_data = sub_pp;
         `RV_ALUOP_SLL:  o_wb_data = sh16_pp ? {sll_pp[0+:H], {H{1'b0}}} : sll_pp;
         `RV_ALUOP_SLT:  o_wb_data = {{(XW-1){1'b0}}, slt_pp};
         `RV_ALUOP_SLTU: o_wb_data = {{(XW-1){1'b0}}, ltu_hi_pp | (eq_hi_pp & ltu_lo_pp)};
         `RV_ALUOP_XOR:  o_wb_data = xor_pp;
         `RV_ALUOP_SRL:  o_wb_data = sh16_pp ? {{H{1'b0}}, srl_pp[H+:H]} : srl_pp;
         `RV_ALUOP_SRA:  o_wb_data = sh16_pp ? {{H{sra_pp[XW-1]}}, sra_pp[H+:H]} : sra_pp;
         `RV_ALUOP_OR:   o_wb_data = or_pp;
         `RV_ALUOP_AND:  o_wb_data = and_pp;
         default:        o_wb_data = '0;
      endcase
   end

   assign o_wb_valid = valid_pp;
   assign o_wb_rd    = rd_pp;

   // decoder must never let an undefined code reach issue
   a_valid_op: assert property (@(posedge i_clk) disable iff (i_rst)
      iss.valid |-> iss.alu_op inside {`RV_ALUOP_ADD, `RV_ALUOP_SUB, `RV_ALUOP_SLL,
                                       `RV_ALUOP_SLT, `RV_ALUOP_SLTU, `RV_ALUOP_XOR,
                                       `RV_ALUOP_SRL, `RV_ALUOP_SRA, `RV_ALUOP_OR,
                                       `RV_ALUOP_AND});

endmodule

// ==== verilog/rv_exec_core.sv ====
// rv_exec_core: RV32I integer execute core, decode through writeback
`include "rv_cfg.svh"

module rv_exec_core (
   input  logic                      i_clk,
   input  logic                      i_rst,
   input  logic                      i_inst_valid,
   input  rv_pkg::inst_u             i_inst,
   output logic                      o_inst_ready,
   output logic                      o_wb_valid,
   output logic [`RV_REG_ADDR_W-1:0] o_wb_rd,
   output logic [`RV_XLEN-1:0]       o_wb_data,
   output logic                      o_illegal
);

   logic [`RV_REG_ADDR_W-1:0] dec_rs1, dec_rs2, dec_rd;
   logic [`RV_XLEN-1:0]       dec_imm;
   logic [`RV_ALUOP_W-1:0]    dec_alu_op;
   logic                      dec_use_imm, dec_uses_rs2, dec_illegal;
   logic [`RV_REG_ADDR_W-1:0] rd_addr1, rd_addr2;
   logic [`RV_XLEN-1:0]       rs1_data, rs2_data;

   issue_if iss ();

   inst_decoder dec_i (
      .i_inst     (i_inst),
      .o_rs1      (dec_rs1),
      .o_rs2      (dec_rs2),
      .o_rd       (dec_rd),
      .o_imm      (dec_imm),
      .o_alu_op   (dec_alu_op),
      .o_use_imm  (dec_use_imm),
      .o_uses_rs2 (dec_uses_rs2),
      .o_illegal  (dec_illegal)
   );

   issue_ctrl issue_i (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_inst_valid  (i_inst_valid),
      .o_inst_ready  (o_inst_ready),
      .i_rs1         (dec_rs1),
      .i_rs2         (dec_rs2),
      .i_uses_rs2    (dec_uses_rs2),
      .i_rd          (dec_rd),
      .i_imm         (dec_imm),
      .i_alu_op      (dec_alu_op),
      .i_use_imm     (dec_use_imm),
      .i_dec_illegal (dec_illegal),
      .o_rd_addr1    (rd_addr1),
      .o_rd_addr2    (rd_addr2),
      .i_wb_valid    (o_wb_valid),
      .i_wb_rd       (o_wb_rd),
      .o_illegal     (o_illegal),
      .iss           (iss.master)
   );

   regfile rf_i (
      .i_clk (i_clk),
      .i_we  (o_wb_valid),
      .i_wa  (o_wb_rd),
      .i_wd  (o_wb_data),
      .i_ra1 (rd_addr1),
      .i_ra2 (rd_addr2),
      .o_rd1 (rs1_data),
      .o_rd2 (rs2_data)
   );

   exec_alu alu_i (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .iss        (iss.slave),
      .i_rs1_data (rs1_data),
      .i_rs2_data (rs2_data),
      .o_wb_valid (o_wb_valid),
      .o_wb_rd    (o_wb_rd),
      .o_wb_data  (o_wb_data)
   );

endmodule

// ==== tests/tb_clock.sv ====
// tb_clock: free-running clock for the testbench
module tb_clock #(
   parameter int PERIOD = 100
) (
   output logic o_clk
);
   timeunit 1ns;
   timeprecision 1ps;

   initial o_clk = 1'b0;

   always #(PERIOD / 2) o_clk = ~o_clk;   // 50 ns high, 50 ns low

endmodule

// ==== tests/tb_rv_exec_core.sv ====
// tb_rv_exec_core: directed tests of the RV32I execute core against a register model
`include "rv_cfg.svh"

module tb_rv_exec_core;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 100;
   localparam int N_INST     = 400;   // rough instruction count over all tests

   logic                      clk;
   logic                      rst;
   logic                      inst_valid;
   rv_pkg::inst_u             inst;
   logic                      inst_ready;
   logic                      wb_valid;
   logic [`RV_REG_ADDR_W-1:0] wb_rd;
   logic [`RV_XLEN-1:0]       wb_data;
   logic                      illegal;

   logic [`RV_XLEN-1:0]       regs [`RV_NUM_REGS];   // reference register state
   logic [31:0]               exp_rd [$];
   logic [31:0]               exp_data [$];
   int                        illegal_pending;
   int                        errors;
   logic [31:0]               lcg_state;
   int                        rr_rd;

   tb_clock #(.PERIOD(CLK_PERIOD)) clk_i (.o_clk(clk));

   rv_exec_core rv_exec_core_i (
      .i_clk        (clk),
      .i_rst        (rst),
      .i_inst_valid (inst_valid),
      .i_inst       (inst),
      .o_inst_ready (inst_ready),
      .o_wb_valid   (wb_valid),
      .o_wb_rd      (wb_rd),
      .o_wb_data    (wb_data),
      .o_illegal    (illegal)
   );

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // result registers rotate over x10..x31
   function automatic int next_rd();
      next_rd = rr_rd;
      rr_rd   = (rr_rd == 31) ? 10 : rr_rd + 1;
   endfunction

   function automatic rv_pkg::inst_u r_word(input logic [6:0] f7, input logic [2:0] f3,
                                            input int rd, input int rs1, input int rs2);
      rv_pkg::inst_u w;
      w.r.funct7 = f7;
      w.r.rs2    = 5'(rs2);
      w.r.rs1    = 5'(rs1);
      w.r.funct3 = f3;
      w.r.rd     = 5'(rd);
      w.r.opcode = `RV_OPC_OP;
      return w;
   endfunction

   function automatic rv_pkg::inst_u i_word(input logic [6:0] opc, input logic [11:0] imm,
                                            input logic [2:0] f3, input int rd, input int rs1);
      rv_pkg::inst_u w;
      w.i.imm    = imm;
      w.i.rs1    = 5'(rs1);
      w.i.funct3 = f3;
      w.i.rd     = 5'(rd);
      w.i.opcode = opc;
      return w;
   endfunction

   function automatic rv_pkg::inst_u u_word(input logic [19:0] imm, input int rd);
      rv_pkg::inst_u w;
      w.u.imm    = imm;
      w.u.rd     = 5'(rd);
      w.u.opcode = `RV_OPC_LUI;
      return w;
   endfunction

   // returns 1 when the core runs the instruction
   function automatic logic model_exec(input rv_pkg::inst_u w, output logic [31:0] res);
      logic [31:0] a;
      logic [31:0] b;
      logic        alt;
      logic        ok;
      a   = regs[w.r.rs1];
      b   = regs[w.r.rs2];
      alt = (w.r.funct7 == 7'h20);
      ok  = 1'b1;
      res = '0;
      if (w.r.opcode == `RV_OPC_LUI) begin
         res = {w.u.imm, 12'h000};
      end else if (w.r.opcode == `RV_OPC_OP || w.r.opcode == `RV_OPC_OPIMM) begin
         if (w.r.opcode == `RV_OPC_OP) begin
            ok = (w.r.funct7 == 7'h00) ||
                 (alt && (w.r.funct3 == 3'b000 || w.r.funct3 == 3'b101));
         end else begin
            b   = {{20{w.i.imm[11]}}, w.i.imm};
            alt = alt && (w.r.funct3 == 3'b101);   // upper imm bits matter only on shifts
            if (w.r.funct3 == 3'b001)
               ok = (w.r.funct7 == 7'h00);
            if (w.r.funct3 == 3'b101)
               ok = (w.r.funct7 == 7'h00) || alt;
         end
         case (w.r.funct3)
            3'b000: res = alt ? a - b : a + b;
            3'b001: res = a << b[4:0];
            3'b010: res = {31'b0, $signed(a) < $signed(b)};
            3'b011: res = {31'b0, a < b};
            3'b100: res = a ^ b;
            3'b101: begin
               if (alt)
                  res = $signed(a) >>> b[4:0];
               else
                  res = a >> b[4:0];
            end
            3'b110: res = a | b;
            default: res = a & b;
         endcase
      end else begin
         ok = 1'b0;   // loads, branches, system
      end
      return ok;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
      end
   endtask

   // present one word, wait for the handshake, then update the model
   task automatic issue(input rv_pkg::inst_u w);
      logic        ok;
      logic [31:0] res;
      logic        ready_seen;
      @(negedge clk);
      inst_valid = 1'b1;
      inst       = w;
      ready_seen = 1'b0;
      while (!ready_seen) begin
         #(CLK_PERIOD / 4);   // ready settled by now
         ready_seen = (inst_ready === 1'b1);
         if (!ready_seen)
            @(negedge clk);
      end
      @(posedge clk);
      ok = model_exec(w, res);
      if (ok) begin
         exp_rd.push_back(32'(w.r.rd));
         exp_data.push_back(res);
         if (w.r.rd != '0)
            regs[w.r.rd] = res;
      end else begin
         illegal_pending++;
      end
   endtask

   task automatic drain();
      @(negedge clk);
      inst_valid = 1'b0;
      while (exp_rd.size() != 0 || illegal_pending != 0)
         @(negedge clk);
      repeat (4) @(negedge clk);   // catch stray writebacks
   endtask

   task automatic load_reg(input int r, input logic [31:0] v);
      logic [19:0] hi;
      hi = v[31:12] + {19'b0, v[11]};   // undo the addi sign extension
      issue(u_word(hi, r));
      issue(i_word(`RV_OPC_OPIMM, v[11:0], 3'b000, r, r));
   endtask

   task automatic reset_test();
      rst        = 1'b1;
      inst_valid = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      #(CLK_PERIOD / 4);
      check("o_wb_valid", 32'(wb_valid), 32'h0);
      check("o_illegal", 32'(illegal), 32'h0);
      check("o_inst_ready", 32'(inst_ready), 32'h1);
   endtask

   task automatic imm_ops_test();
      logic [31:0] v;
      logic [11:0] imm;
      logic [4:0]  sh;
      int          src;
      for (int r = 1; r < `RV_NUM_REGS; r++)
         load_reg(r, next_random());
      for (int k = 0; k < 8; k++) begin
         src = 1 + (k % 9);
         v   = next_random();
         sh  = v[20:16];
         case (k % 4)
            0: imm = 12'h800;   // most negative
            1: imm = 12'hfff;
            2: imm = 12'h7ff;
            default: imm = v[11:0];
         endcase
         issue(i_word(`RV_OPC_OPIMM, imm, 3'b000, next_rd(), src));
         issue(i_word(`RV_OPC_OPIMM, imm, 3'b010, next_rd(), src));
         issue(i_word(`RV_OPC_OPIMM, imm, 3'b011, next_rd(), src));
         issue(i_word(`RV_OPC_OPIMM, imm, 3'b100, next_rd(), src));
         issue(i_word(`RV_OPC_OPIMM, imm, 3'b110, next_rd(), src));
         issue(i_word(`RV_OPC_OPIMM, imm, 3'b111, next_rd(), src));
         issue(i_word(`RV_OPC_OPIMM, {7'h00, sh}, 3'b001, next_rd(), src));
         issue(i_word(`RV_OPC_OPIMM, {7'h00, sh}, 3'b101, next_rd(), src));
         issue(i_word(`RV_OPC_OPIMM, {7'h20, sh}, 3'b101, next_rd(), src));
      end
   endtask

   task automatic reg_ops_test();
      logic [31:0] a;
      logic [6:0]  f7s [10];
      logic [2:0]  f3s [10];
      int          s1 [7];
      int          s2 [7];
      f7s = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
      f3s = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
      s1  = '{1, 3, 5, 6, 5, 7, 2};
      s2  = '{2, 4, 6, 5, 7, 5, 2};
      a   = next_random();
      load_reg(5, a);
      load_reg(6, {~a[31:16], a[15:0]});   // upper half differs and the sign flips
      load_reg(7, {a[31:16], ~a[15:0]});   // lower half differs
      for (int p = 0; p < 7; p++)
         for (int op = 0; op < 10; op++)
            issue(r_word(f7s[op], f3s[op], next_rd(), s1[p], s2[p]));
   endtask

   task automatic shift_test();
      logic [31:0] v;
      int          src;
      load_reg(8, 32'h8765_4321);
      for (int s = 0; s < 32; s++) begin
         v   = next_random();
         src = (s % 2 == 0) ? 8 : 1;
         // junk above bit 4 of the amount must be ignored
         issue(i_word(`RV_OPC_OPIMM, {v[11:5], 5'(s)}, 3'b000, 9, 0));
         issue(r_word(7'h00, 3'b001, next_rd(), src, 9));
         issue(r_word(7'h00, 3'b101, next_rd(), src, 9));
         issue(r_word(7'h20, 3'b101, next_rd(), src, 9));
      end
   endtask

   // x5 and x6 feed each other with an independent ori in between
   task automatic dependency_test();
      int rd;
      int rs;
      for (int k = 0; k < 12; k++) begin
         rd = (k % 2 == 1) ? 6 : 5;
         rs = (k % 2 == 1) ? 5 : 6;
         case (k % 4)
            0: issue(i_word(`RV_OPC_OPIMM, 12'(k * 291 - 1000), 3'b000, rd, rs));
            1: issue(r_word(7'h20, 3'b000, rd, rs, 2));
            2: issue(r_word(7'h00, 3'b100, rd, rs, 3));
            default: issue(r_word(7'h20, 3'b101, rd, rs, 4));
         endcase
         issue(i_word(`RV_OPC_OPIMM, 12'(k), 3'b110, 20 + k, 3));
      end
   endtask

   task automatic illegal_test();
      rv_pkg::inst_u w;
      issue(i_word(7'b0000011, 12'h004, 3'b010, 12, 1));   // lw
      w          = r_word(7'h00, 3'b000, 12, 1, 2);
      w.r.opcode = 7'b1100011;                            // beq
      issue(w);
      issue(r_word(7'h01, 3'b000, 12, 1, 2));              // mul
      issue(i_word(`RV_OPC_OPIMM, {7'h20, 5'd3}, 3'b001, 12, 1));
      drain();
      issue(i_word(`RV_OPC_OPIMM, 12'h000, 3'b000, 13, 12));   // x12 still holds its old value
      issue(i_word(`RV_OPC_OPIMM, 12'h005, 3'b000, 0, 1));   // dropped by x0
      issue(u_word(20'hfffff, 0));
      issue(r_word(7'h00, 3'b000, 14, 0, 0));
      issue(i_word(`RV_OPC_OPIMM, 12'h000, 3'b110, 15, 0));
      drain();
   endtask

   // match writebacks and illegal pulses against what was accepted
   always @(negedge clk) begin
      if (!rst && wb_valid === 1'b1) begin
         if (exp_rd.size() == 0) begin
            errors++;
            $display("unexpected writeback to x%0d with nothing outstanding", wb_rd);
         end else begin
            check("o_wb_rd", 32'(wb_rd), exp_rd.pop_front());
            check("o_wb_data", wb_data, exp_data.pop_front());
         end
      end
      if (!rst && illegal === 1'b1) begin
         if (illegal_pending == 0) begin
            errors++;
            $display("o_illegal pulsed for an instruction the core should run");
         end else begin
            illegal_pending--;
         end
      end
   end

   initial begin
      #(N_INST * 20 * CLK_PERIOD);
      $display("timeout after %0d cycles, results or illegal pulses missing", N_INST * 20);
      $display("Testbench failed");
      $finish;
   end

   initial begin
      rst             = 1'b1;
      inst_valid      = 1'b0;
      inst            = '0;
      errors          = 0;
      illegal_pending = 0;
      lcg_state       = 32'd29;
      rr_rd           = 10;
      for (int r = 0; r < `RV_NUM_REGS; r++)
         regs[r] = '0;
      reset_test();
      imm_ops_test();
      drain();
      reg_ops_test();
      drain();
      shift_test();
      drain();
      dependency_test();
      drain();
      illegal_test();
      $display("tests done: %0d errors, %0d writebacks outstanding", errors, exp_rd.size());
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/rv_pkg.sv
verilog/issue_if.sv
verilog/inst_decoder.sv
verilog/issue_ctrl.sv
verilog/regfile.sv
verilog/exec_alu.sv
verilog/rv_exec_core.sv
tests/tb_clock.sv
tests/tb_rv_exec_core.sv

// ==== Makefile ====
# Verilator flow for the RV32I execute core

VERILATOR ?= verilator
TOP       ?= tb_rv_exec_core
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FILELIST)) verilog/rv_cfg.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
